// File: src/fft_pkg.sv
/* shared widths, fixed-point constants, twiddle tables and core state
   encoding for the 16-point FFT */

package fft_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int N_POINTS = 16;
    localparam int N_STAGES = 4;
    localparam int N_BFLY   = 8;

    // internal word is Q16.16
    localparam int FRAC_BITS = 16;
    // input Q8.8 lands in bits 23..8 of the internal word
    localparam int IN_SHIFT  = 8;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] sample_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [3:0]         point_idx_t;
    typedef logic [2:0]         tw_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        STAGE1,
        STAGE2,
        STAGE3,
        STAGE4,
        DONE
    } core_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // twiddles, W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
    ////////////////////////////////////////////////////////////////////////////

    localparam acc_t TW_REAL [N_POINTS/2] = '{
        32'sh00010000, 32'sh0000EC83, 32'sh0000B504, 32'sh000061F7,
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D
    };

    localparam acc_t TW_IMAG [N_POINTS/2] = '{
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D,
        32'shFFFF0000, 32'shFFFF137D, 32'shFFFF4AFC, 32'shFFFF9E09
    };

endpackage

// File: src/sample_collector.sv
/* serial to parallel collector, gathers 16 samples into one block */

`timescale 1ns/1ps

module sample_collector (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    output fft_pkg::acc_t    block [fft_pkg::N_POINTS],
    output logic             block_ready
);
    import fft_pkg::*;

    point_idx_t cnt;

    // point counter, wraps after the last slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= '0;
            block_ready <= 1'b0;
        end else begin
            block_ready <= fir_valid && (cnt == point_idx_t'(N_POINTS - 1));
            if (fir_valid) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // sign extend, then move into the Q16.16 position
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            block[cnt] <= acc_t'(fir_d) << IN_SHIFT;
        end
    end

    // a new block needs 16 more samples, so never two in a row
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst)
        block_ready |=> !block_ready
    );

endmodule

// File: src/butterfly.sv
/* radix-2 DIF butterfly, sum on x and twiddled difference on y */

`timescale 1ns/1ps

module butterfly (
    input  fft_pkg::acc_t a_re,
    input  fft_pkg::acc_t a_im,
    input  fft_pkg::acc_t b_re,
    input  fft_pkg::acc_t b_im,
    input  fft_pkg::acc_t w_re,
    input  fft_pkg::acc_t w_im,
    output fft_pkg::acc_t x_re,
    output fft_pkg::acc_t x_im,
    output fft_pkg::acc_t y_re,
    output fft_pkg::acc_t y_im
);
    import fft_pkg::*;

    acc_t d_re;
    acc_t d_im;
    acc_t nd_im;

    logic signed [63:0] p_rr;
    logic signed [63:0] p_ni;
    logic signed [63:0] p_ri;
    logic signed [63:0] p_ir;

    assign x_re = a_re + b_re;
    assign x_im = a_im + b_im;

    assign d_re  = a_re - b_re;
    assign d_im  = a_im - b_im;
    // negated imag difference, product is truncated on its own
    assign nd_im = b_im - a_im;

    assign p_rr = d_re * w_re;
    assign p_ni = nd_im * w_im;
    assign p_ri = d_re * w_im;
    assign p_ir = d_im * w_re;

    // each product back to Q16.16 before the pair is added
    assign y_re = p_rr[FRAC_BITS +: 32] + p_ni[FRAC_BITS +: 32];
    assign y_im = p_ri[FRAC_BITS +: 32] + p_ir[FRAC_BITS +: 32];

endmodule

// File: src/fft_core.sv
/* in-place 16-point FFT core, stage sequencer, ping-pong buffers,
   eight butterflies and bit-reversed readout */

`timescale 1ns/1ps

module fft_core (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::acc_t    block [fft_pkg::N_POINTS],
    input  logic             block_ready,
    output logic             result_valid,
    output fft_pkg::sample_t result_re [fft_pkg::N_POINTS],
    output fft_pkg::sample_t result_im [fft_pkg::N_POINTS]
);
    import fft_pkg::*;

    localparam int STAGE_W = $clog2(N_STAGES);

    core_state_e        state;
    core_state_e        state_nx;
    logic [STAGE_W-1:0] stage;
    logic               running;
    logic               rd;
    logic               wr;

    acc_t buf_re [2][N_POINTS];
    acc_t buf_im [2][N_POINTS];

    point_idx_t a_idx  [N_BFLY];
    point_idx_t b_idx  [N_BFLY];
    tw_idx_t    tw_idx [N_BFLY];

    acc_t x_re [N_BFLY];
    acc_t x_im [N_BFLY];
    acc_t y_re [N_BFLY];
    acc_t y_im [N_BFLY];

    function automatic point_idx_t bit_rev(input point_idx_t i);
        point_idx_t r;
        for (int j = 0; j < $bits(point_idx_t); j++) begin
            r[j] = i[$bits(point_idx_t) - 1 - j];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (block_ready) state_nx = STAGE1;
            STAGE1:  state_nx = STAGE2;
            STAGE2:  state_nx = STAGE3;
            STAGE3:  state_nx = STAGE4;
            STAGE4:  state_nx = DONE;
            DONE:    state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    // zero based stage number while a stage is running
    always_comb begin
        running = 1'b1;
        case (state)
            STAGE1: stage = STAGE_W'(0);
            STAGE2: stage = STAGE_W'(1);
            STAGE3: stage = STAGE_W'(2);
            STAGE4: stage = STAGE_W'(3);
            default: begin
                stage   = '0;
                running = 1'b0;
            end
        endcase
    end

    // odd stages read buffer 0, even stages read buffer 1
    assign rd = stage[0];
    assign wr = ~stage[0];

    assign result_valid = (state == DONE);

    ////////////////////////////////////////////////////////////////////////////
    // pairing and twiddle indexing
    ////////////////////////////////////////////////////////////////////////////

    // span halves every stage, twiddle step doubles
    always_comb begin
        int span;
        int pos;
        span = N_BFLY >> stage;
        for (int k = 0; k < N_BFLY; k++) begin
            pos       = k & (span - 1);
            a_idx[k]  = point_idx_t'(((k - pos) << 1) + pos);
            b_idx[k]  = point_idx_t'(((k - pos) << 1) + pos + span);
            tw_idx[k] = tw_idx_t'(pos << stage);
        end
    end

    for (genvar k = 0; k < N_BFLY; k++) begin : g_bfly
        butterfly u_bfly (
            .a_re (buf_re[rd][a_idx[k]]),
            .a_im (buf_im[rd][a_idx[k]]),
            .b_re (buf_re[rd][b_idx[k]]),
            .b_im (buf_im[rd][b_idx[k]]),
            .w_re (TW_REAL[tw_idx[k]]),
            .w_im (TW_IMAG[tw_idx[k]]),
            .x_re (x_re[k]),
            .x_im (x_im[k]),
            .y_re (y_re[k]),
            .y_im (y_im[k])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // buffers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == IDLE && block_ready) begin
            // real input only
            buf_re[0] <= block;
            buf_im[0] <= '{default: '0};
        end else if (running) begin
            for (int k = 0; k < N_BFLY; k++) begin
                buf_re[wr][a_idx[k]] <= x_re[k];
                buf_im[wr][a_idx[k]] <= x_im[k];
                buf_re[wr][b_idx[k]] <= y_re[k];
                buf_im[wr][b_idx[k]] <= y_im[k];
            end
        end
    end

    // four stages end back in buffer 0, DIF leaves bins bit reversed
    always_comb begin
        for (int b = 0; b < N_POINTS; b++) begin
            result_re[b] = buf_re[0][bit_rev(point_idx_t'(b))][IN_SHIFT +: $bits(sample_t)];
            result_im[b] = buf_im[0][bit_rev(point_idx_t'(b))][IN_SHIFT +: $bits(sample_t)];
        end
    end

    // the collector must not hand over a block while a transform runs
    a_ready_idle: assert property (
        @(posedge clk) disable iff (rst)
        block_ready |-> state == IDLE
    );

endmodule

// File: src/output_serializer.sv
/* two-beat output register, real bins first then imaginary bins */

`timescale 1ns/1ps

module output_serializer (
    input  logic             clk,
    input  logic             rst,
    input  logic             result_valid,
    input  fft_pkg::sample_t result_re [fft_pkg::N_POINTS],
    input  fft_pkg::sample_t result_im [fft_pkg::N_POINTS],
    output logic             fft_valid,
    output fft_pkg::sample_t fft_d [fft_pkg::N_POINTS]
);
    import fft_pkg::*;

    // high while the imaginary beat is pending
    logic    imag_next;
    sample_t im_hold [N_POINTS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fft_valid <= 1'b0;
            imag_next <= 1'b0;
            fft_d     <= '{default: '0};
        end else begin
            fft_valid <= result_valid | imag_next;
            imag_next <= result_valid;
            if (result_valid) begin
                fft_d <= result_re;
            end else if (imag_next) begin
                fft_d <= im_hold;
            end
        end
    end

    // core results only last one cycle, keep the imag half
    always_ff @(posedge clk) begin
        if (result_valid) begin
            im_hold <= result_im;
        end
    end

    // real and imag beats only, blocks are far apart
    a_two_beats: assert property (
        @(posedge clk) disable iff (rst)
        fft_valid ##1 fft_valid |=> !fft_valid
    );

endmodule

// File: src/drain_monitor.sv
/* done pulse once the input stream ended and the output drained */

`timescale 1ns/1ps

module drain_monitor (
    input  logic clk,
    input  logic rst,
    input  logic fir_valid,
    input  logic fft_valid,
    output logic done
);
    logic fir_q;
    logic fft_q;
    logic in_end;
    logic out_end;
    // input has stopped, waiting for the last beats
    logic wait_drain;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_q <= 1'b0;
            fft_q <= 1'b0;
        end else begin
            fir_q <= fir_valid;
            fft_q <= fft_valid;
        end
    end

    // falling edges
    assign in_end  = fir_q & ~fir_valid;
    assign out_end = fft_q & ~fft_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_drain <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= wait_drain & out_end;
            if (wait_drain && out_end) begin
                wait_drain <= 1'b0;
            end else if (in_end) begin
                wait_drain <= 1'b1;
            end
        end
    end

endmodule

// File: src/fft16_top.sv
/* 16-point FFT top level, collector, core, serializer and drain monitor */

`timescale 1ns/1ps

module fft16_top (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    output logic             fft_valid,
    output fft_pkg::sample_t fft_d [fft_pkg::N_POINTS],
    output logic             done
);
    import fft_pkg::*;

    acc_t    block [N_POINTS];
    logic    block_ready;
    logic    result_valid;
    sample_t result_re [N_POINTS];
    sample_t result_im [N_POINTS];

    sample_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .block       (block),
        .block_ready (block_ready)
    );

    fft_core u_core (
        .clk          (clk),
        .rst          (rst),
        .block        (block),
        .block_ready  (block_ready),
        .result_valid (result_valid),
        .result_re    (result_re),
        .result_im    (result_im)
    );

    output_serializer u_serializer (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_re    (result_re),
        .result_im    (result_im),
        .fft_valid    (fft_valid),
        .fft_d        (fft_d)
    );

    drain_monitor u_drain (
        .clk       (clk),
        .rst       (rst),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done)
    );

endmodule

// File: verification/fft16_model.svh
/* integer reference for the 16-point FFT, twiddle values and the
   LCG that produces random samples */

`ifndef FFT16_MODEL_SVH
`define FFT16_MODEL_SVH

// cos and -sin of 2*pi*k/16 scaled by 65536
localparam int TW_RE_REF [8] = '{65536, 60547, 46340, 25079, 0, -25079, -46340, -60547};
localparam int TW_IM_REF [8] = '{0, -25079, -46340, -60547, -65536, -60547, -46340, -25079};

int unsigned lcg_state = 36;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// uniform in -2047..2047 so a bin cannot overflow
function automatic int random_sample();
    int unsigned r;
    r = lcg_next();
    return int'((r >> 16) % 4095) - 2047;
endfunction

function automatic int rev4(input int i);
    return ((i & 1) << 3) | ((i & 2) << 1) | ((i & 4) >> 1) | ((i & 8) >> 3);
endfunction

// 64-bit product, keep bits 47..16
function automatic int mul_q16(input int a, input int b);
    longint p;
    p = longint'(a) * longint'(b);
    return int'(p >>> 16);
endfunction

task automatic fft_model(input int x [16], output int bin_re [16], output int bin_im [16]);
    int re [16];
    int im [16];
    int span;
    int a;
    int b;
    int k;
    int dre;
    int dim;
    for (int i = 0; i < 16; i++) begin
        re[i] = x[i] <<< 8;
        im[i] = 0;
    end
    for (int s = 0; s < 4; s++) begin
        span = 8 >> s;
        for (int g = 0; g < 16; g += 2 * span) begin
            for (int p = 0; p < span; p++) begin
                a = g + p;
                b = a + span;
                k = p << s;
                dre = re[a] - re[b];
                dim = im[a] - im[b];
                re[a] = re[a] + re[b];
                im[a] = im[a] + im[b];
                re[b] = mul_q16(dre, TW_RE_REF[k]) + mul_q16(-dim, TW_IM_REF[k]);
                im[b] = mul_q16(dre, TW_IM_REF[k]) + mul_q16(dim, TW_RE_REF[k]);
            end
        end
    end
    // bins come out in bit reversed order, Q8.8 from bits 23..8
    for (int i = 0; i < 16; i++) begin
        bin_re[i] = int'(shortint'(re[rev4(i)] >>> 8));
        bin_im[i] = int'(shortint'(im[rev4(i)] >>> 8));
    end
endtask

`endif

// File: verification/fft16_tb.sv
/* testbench for the 16-point FFT, stimulus table, reference compare,
   two-beat output and done pulse checks */

`timescale 1ns/1ps

module fft16_tb;
    import fft_pkg::*;

    `include "fft16_model.svh"

    localparam int N_BLK = 9;
    localparam int WAIT_MAX = 200;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table with kind 0 impulse, 1 dc, 2 nyquist and 3 random
    ////////////////////////////////////////////////////////////////////////////

    localparam int KIND [N_BLK] = '{0, 0, 1, 2, 3, 3, 3, 3, 3};
    localparam int VAL  [N_BLK] = '{300, -2047, 100, 2047, 0, 0, 0, 0, 0};
    // fir_valid stays high into the next block
    localparam bit CONT [N_BLK] = '{0, 0, 0, 0, 0, 1, 1, 0, 0};

    logic    clk;
    logic    rst;
    sample_t fir_d;
    logic    fir_valid;
    logic    fft_valid;
    sample_t fft_d [N_POINTS];
    logic    done;

    int smp    [N_BLK][16];
    int exp_re [N_BLK][16];
    int exp_im [N_BLK][16];
    int errors;
    int tests;
    int failed_tests;
    bit timed_out;

    fft16_top UUT (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .fft_d     (fft_d),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(
        input logic signed [31:0] got,
        input logic signed [31:0] expected,
        input string              msg
    );
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, msg, got, expected);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %0d %s finished with %0d errors", tests, name, errors - err_before);
    endtask

    // closed form bins for impulse, dc and nyquist blocks
    function automatic int closed_bin(input int kind, input int v, input int bin);
        case (kind)
            0: return v;
            1: return (bin == 0) ? 16 * v : 0;
            default: return (bin == 8) ? 16 * v : 0;
        endcase
    endfunction

    task automatic build_stimulus();
        for (int i = 0; i < N_BLK; i++) begin
            for (int j = 0; j < 16; j++) begin
                case (KIND[i])
                    0: smp[i][j] = (j == 0) ? VAL[i] : 0;
                    1: smp[i][j] = VAL[i];
                    2: smp[i][j] = (j % 2 == 0) ? VAL[i] : -VAL[i];
                    default: smp[i][j] = random_sample();
                endcase
            end
            if (KIND[i] == 3) begin
                fft_model(smp[i], exp_re[i], exp_im[i]);
            end else begin
                for (int j = 0; j < 16; j++) begin
                    exp_re[i][j] = closed_bin(KIND[i], VAL[i], j);
                    exp_im[i][j] = 0;
                end
            end
        end
    endtask

    task automatic drive_blocks();
        for (int i = 0; i < N_BLK; i++) begin
            for (int j = 0; j < 16; j++) begin
                @(negedge clk);
                fir_valid = 1'b1;
                fir_d     = sample_t'(smp[i][j]);
            end
            if (!CONT[i]) begin
                @(negedge clk);
                fir_valid = 1'b0;
                fir_d     = '0;
                repeat (3) @(negedge clk);
            end
        end
        @(negedge clk);
        fir_valid = 1'b0;
    endtask

    task automatic check_block(input int i);
        int t;
        int err_before;
        err_before = errors;
        t = 0;
        while (!fft_valid && t < WAIT_MAX) begin
            check_value(done, 0, "done early");
            @(negedge clk);
            t++;
        end
        if (!fft_valid) begin
            $display("timed out waiting for the output of block %0d", i);
            timed_out = 1'b1;
            return;
        end
        // real beat, then imag beat, then valid drops
        for (int b = 0; b < 16; b++) begin
            check_value(fft_d[b], exp_re[i][b], $sformatf("block %0d re bin %0d", i, b));
        end
        @(negedge clk);
        check_value(fft_valid, 1, "fft_valid second beat");
        for (int b = 0; b < 16; b++) begin
            check_value(fft_d[b], exp_im[i][b], $sformatf("block %0d im bin %0d", i, b));
        end
        @(negedge clk);
        check_value(fft_valid, 0, "fft_valid after two beats");
        check_value(done, 0, "done with last beat");
        if (!CONT[i]) begin
            @(negedge clk);
            check_value(done, 1, "done pulse");
            @(negedge clk);
            check_value(done, 0, "done longer than one cycle");
        end
        end_test($sformatf("block %0d kind %0d", i, KIND[i]), err_before);
    endtask

    task automatic check_outputs();
        for (int i = 0; i < N_BLK && !timed_out; i++) begin
            check_block(i);
        end
    endtask

    initial begin
        int err_before;
        rst       = 1'b1;
        fir_d     = '0;
        fir_valid = 1'b0;
        errors    = 0;
        tests     = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        build_stimulus();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_before = errors;
        repeat (10) begin
            @(negedge clk);
            check_value(fft_valid, 0, "fft_valid after reset");
            check_value(done, 0, "done after reset");
        end
        end_test("reset", err_before);

        fork
            drive_blocks();
            check_outputs();
        join

        // no second done without new input
        err_before = errors;
        repeat (30) begin
            @(negedge clk);
            check_value(done, 0, "done repeated");
            check_value(fft_valid, 0, "fft_valid without input");
        end
        end_test("done once", err_before);

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+verification
src/fft_pkg.sv
src/sample_collector.sv
src/butterfly.sv
src/fft_core.sv
src/output_serializer.sv
src/drain_monitor.sv
src/fft16_top.sv
verification/fft16_tb.sv
